/* all.f */
vdp_cmd_pkg.sv
vdp_cmd_regs.sv
vdp_cmd_pixel.sv
vdp_vram_port.sv
vdp_cmd_engine.sv
vdp_command.sv
tb_vram_model.sv
tb_vdp_assertions.sv
tb_vdp_command.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module tb_vdp_command -f all.f -o tb_vdp_command &&
./obj_dir/tb_vdp_command ||
{ echo "Simulation failed"; exit 1; }

/* tb_vdp_assertions.sv */
// Concurrent checks on the VRAM access port
// Every access start raises a pending request, requests idle in reset
// Address held while an access is pending
`timescale 1ns/1ps
`default_nettype none

module tb_vdp_assertions #(
  parameter int vram_aw = vdp_cmd_pkg::VRAM_AW
) (
  input logic               reset,
  input logic               clk21m,
  input logic               acc_go,
  input logic               acc_busy,
  input logic               vram_wr_req,
  input logic               vram_rd_req,
  input logic [vram_aw-1:0] vram_addr
);

  // A started access shows up as a pending toggle
  go_starts_access: assert property (
    @(posedge reset) disable iff (clk21m) acc_go |=> acc_busy
  ) else $error("acc_go did not start a pending VRAM access");

  // Both toggles parked at zero
  req_low_in_reset: assert property (
    @(posedge reset) clk21m |-> (!vram_wr_req && !vram_rd_req)
  ) else $error("VRAM request set during reset");

  addr_stable_while_busy: assert property (
    @(posedge reset) disable iff (clk21m) acc_busy |=> $stable(vram_addr)
  ) else $error("VRAM address changed during a pending access");

endmodule

bind vdp_vram_port tb_vdp_assertions #(
  .vram_aw (vram_aw)
) i_tb_vdp_assertions (
  .reset       (reset),
  .clk21m      (clk21m),
  .acc_go      (acc_go),
  .acc_busy    (acc_busy),
  .vram_wr_req (vram_wr_req),
  .vram_rd_req (vram_rd_req),
  .vram_addr   (vram_addr)
);

`default_nettype wire

/* tb_vdp_command.sv */
// Testbench top for the block-graphics command engine
// Clock and reset, register write handshake, trace stepping
// VRAM, color and command checks, timeout scaled by trace length
`timescale 1ns/1ps
`default_nettype none

module tb_vdp_command;
  import vdp_cmd_pkg::*;

  localparam int TRACE_DEPTH = 256;

  logic         reset;
  logic         clk21m;
  screen_mode_t mode;
  logic         reg_wr_req;
  logic [3:0]   reg_num;
  color_t       reg_data;
  logic         reg_wr_ack;
  logic         vram_wr_req;
  logic         vram_rd_req;
  logic         vram_wr_ack;
  logic         vram_rd_ack;
  vram_addr_t   vram_addr;
  color_t       vram_wr_data;
  color_t       vram_rd_data;
  color_t       clr;
  logic         ce;
  cmd_code_t    cur_cmd;

  // Trace entry is kind[31:28], arg[27:8], val[7:0]
  logic [31:0]  trace [0:TRACE_DEPTH-1];
  int           trace_len;
  int           cycles = 0;
  int           cycle_limit = 0;

  vdp_command #(
    .vram_aw (VRAM_AW)
  ) i_vdp_command (
    .reset        (reset),
    .clk21m       (clk21m),
    .mode         (mode),
    .reg_wr_req   (reg_wr_req),
    .reg_num      (reg_num),
    .reg_data     (reg_data),
    .vram_wr_ack  (vram_wr_ack),
    .vram_rd_ack  (vram_rd_ack),
    .vram_rd_data (vram_rd_data),
    .reg_wr_ack   (reg_wr_ack),
    .vram_wr_req  (vram_wr_req),
    .vram_rd_req  (vram_rd_req),
    .vram_addr    (vram_addr),
    .vram_wr_data (vram_wr_data),
    .clr          (clr),
    .ce           (ce),
    .cur_cmd      (cur_cmd)
  );

  tb_vram_model i_tb_vram_model (
    .reset        (reset),
    .clk21m       (clk21m),
    .vram_wr_req  (vram_wr_req),
    .vram_rd_req  (vram_rd_req),
    .vram_addr    (vram_addr),
    .vram_wr_data (vram_wr_data),
    .vram_wr_ack  (vram_wr_ack),
    .vram_rd_ack  (vram_rd_ack),
    .vram_rd_data (vram_rd_data)
  );

  // 8 ns period, design clock is named reset
  always #4 reset = ~reset;

  always @(posedge reset) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: trace not finished within %0d clock cycles", cycle_limit);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Toggle request, wait for the matching acknowledge
  task automatic write_reg(input logic [7:0] num, input color_t data);
    reg_num    = 4'(num - 8'(REG_BASE));
    reg_data   = data;
    reg_wr_req = ~reg_wr_req;
    do @(negedge reset); while (reg_wr_ack != reg_wr_req);
  endtask

  // ce rises two edges after the R46 acknowledge
  task automatic wait_idle();
    repeat (2) @(negedge reset);
    while (ce) @(negedge reset);
  endtask

  task automatic run_step(input logic [31:0] step);
    logic [3:0]  kind;
    logic [19:0] arg;
    color_t      val;
    kind = step[31:28];
    arg  = step[27:8];
    val  = step[7:0];
    case (kind)
      4'h1: write_reg(arg[7:0], val);
      4'h2: mode = screen_mode_t'(val[3:0]);
      4'h3: wait_idle();
      4'h4: repeat (arg) @(negedge reset);
      4'h5: check_value(32'(i_tb_vram_model.mem[arg[16:0]]), 32'(val),
                        $sformatf("VRAM byte %05h", arg[16:0]));
      4'h6: check_value(32'(clr), 32'(val), "color register");
      4'h7: check_value(32'(cur_cmd), 32'(val), "current command");
      default: begin
        $display("Trace entry %08h has an unknown kind", step);
        $display("TESTS FAILED");
        $fatal(1, "bad trace entry");
      end
    endcase
  endtask

  initial begin
    int i;
    reset      = 1'b0;
    clk21m     = 1'b1;
    mode       = '0;
    reg_wr_req = 1'b0;
    reg_num    = '0;
    reg_data   = '0;
    for (i = 0; i < TRACE_DEPTH; i++) begin
      trace[i] = '0;
    end
    $readmemh("vdp_trace.txt", trace);
    // Kind 0 ends the trace
    trace_len = 0;
    while (trace_len < TRACE_DEPTH && trace[trace_len][31:28] != 4'h0) begin
      trace_len++;
    end
    if (trace_len == 0) begin
      $display("Trace file is missing or holds no entries");
      $display("TESTS FAILED");
      $fatal(1, "empty trace");
    end else begin
      cycle_limit = 400 * trace_len + 200;
      repeat (4) @(negedge reset);
      clk21m = 1'b0;
      for (i = 0; i < trace_len; i++) begin
        run_step(trace[i]);
      end
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tb_vram_model.sv */
// 128 KB VRAM model with toggle handshake
// Known fill pattern folded from the whole address
// Acknowledge after a random delay of 1 to 6 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_vram_model (
  input  logic                    reset,
  input  logic                    clk21m,
  input  logic                    vram_wr_req,
  input  logic                    vram_rd_req,
  input  vdp_cmd_pkg::vram_addr_t vram_addr,
  input  vdp_cmd_pkg::color_t     vram_wr_data,
  output logic                    vram_wr_ack,
  output logic                    vram_rd_ack,
  output vdp_cmd_pkg::color_t     vram_rd_data
);
  import vdp_cmd_pkg::*;

  color_t     mem [0:(1 << VRAM_AW) - 1];
  int         seed;
  int         delay;
  int         a;
  logic       pending;
  vram_addr_t fill_addr;

  initial begin
    seed = 32'h78cd;
    for (a = 0; a < (1 << VRAM_AW); a++) begin
      fill_addr = vram_addr_t'(a);
      mem[a] = fill_addr[7:0] ^ fill_addr[15:8] ^ {7'h00, fill_addr[16]};
    end
  end

  // Runs on the falling edge so acks settle before the DUT samples
  always @(negedge reset or posedge clk21m) begin
    if (clk21m) begin
      vram_wr_ack  <= 1'b0;
      vram_rd_ack  <= 1'b0;
      vram_rd_data <= '0;
      pending      <= 1'b0;
      delay        <= 0;
    end else if (!pending) begin
      if ((vram_wr_req != vram_wr_ack) || (vram_rd_req != vram_rd_ack)) begin
        pending <= 1'b1;
        delay   <= 1 + (($random(seed) & 32'h7fff_ffff) % 6);
      end
    end else if (delay > 1) begin
      delay <= delay - 1;
    end else begin
      pending <= 1'b0;
      if (vram_wr_req != vram_wr_ack) begin
        mem[vram_addr] = vram_wr_data;
        vram_wr_ack   <= vram_wr_req;
      end else begin
        // Read data valid together with the ack
        vram_rd_data <= mem[vram_addr];
        vram_rd_ack  <= vram_rd_req;
      end
    end
  end

endmodule

`default_nettype wire

/* vdp_cmd_engine.sv */
// Command engine FSM for HMMV, LMMV, LMMM, PSET and POINT
// Working X, source X and NX counters with right-edge clipping
// VRAM access sequencing and loop write-backs to the registers
`timescale 1ns/1ps
`default_nettype none

module vdp_cmd_engine (
  input  logic                      reset,
  input  logic                      clk21m,
  input  vdp_cmd_pkg::screen_mode_t mode,
  input  vdp_cmd_pkg::cmd_regs_t    regs,
  input  vdp_cmd_pkg::color_t       clr,
  input  logic                      start,
  input  logic                      hold,
  input  logic                      acc_busy,
  input  vdp_cmd_pkg::color_t       rd_point,
  input  vdp_cmd_pkg::color_t       merged,
  input  vdp_cmd_pkg::color_t       col_mask,
  input  vdp_cmd_pkg::color_t       rd_byte,
  output logic                      ce,
  output vdp_cmd_pkg::cmd_code_t    cur_cmd,
  output logic                      acc_go,
  output logic                      acc_we,
  output vdp_cmd_pkg::coord_x_t     acc_x,
  output vdp_cmd_pkg::coord_y_t     acc_y,
  output vdp_cmd_pkg::color_t       acc_wdata,
  output logic [1:0]                x_low,
  output vdp_cmd_pkg::color_t       src_col,
  output logic                      byte_cmd,
  output logic                      ny_upd,
  output logic                      y_upd,
  output logic                      clr_wr,
  output vdp_cmd_pkg::color_t       clr_in
);
  import vdp_cmd_pkg::*;

  eng_state_t state;
  logic       init;
  coord_x_t   x_cnt;
  coord_x_t   sx_cnt;
  coord_x_t   x_delta;
  count_t     nx_cnt;
  count_t     nx_load;
  color_t     wdata;
  color_t     src_pix;
  logic [1:0] max_mask;
  logic       run;
  logic       chk;
  logic       chk_end;
  logic       x_end;
  logic       y_end;
  logic       edge_d;
  logic       edge_s;
  logic       copy_cmd;

  assign byte_cmd = (cur_cmd[3:2] == 2'b11);
  assign copy_cmd = (cur_cmd == CMD_LMMM);
  // CPU writes win, a start overrides the current step
  assign run      = ~start & ~hold;
  assign chk      = run & (state == ST_CHKLOOP);

  // Byte commands step a whole byte of pixels
  always_comb begin
    nx_load = regs.nx;
    x_delta = 10'd1;
    if (byte_cmd && (mode.g4 || mode.g6)) begin
      nx_load = {1'b0, regs.nx[9:1]};
      x_delta = 10'd2;
    end else if (byte_cmd && mode.g5) begin
      nx_load = {2'b00, regs.nx[9:2]};
      x_delta = 10'd4;
    end
    if (regs.dix) begin
      x_delta = ~x_delta + 10'd1;
    end
  end

  // Right edge at 256 or 512 pixels
  assign max_mask = (mode.g5 | mode.g6) ? 2'b10 : 2'b01;
  assign edge_d   = ((x_cnt[9:8] & max_mask) == max_mask);
  assign edge_s   = ((sx_cnt[9:8] & max_mask) == max_mask);

  always_comb begin
    case (cur_cmd)
      CMD_HMMV, CMD_LMMV: x_end = (nx_cnt == '0) | edge_d;
      CMD_LMMM:           x_end = (nx_cnt == '0) | edge_d | edge_s;
      default:            x_end = 1'b1;
    endcase
  end

  // Upward copies also stop at the top source row
  assign y_end   = (regs.ny == 10'd1)
                 | (regs.diy & (regs.dy == '0))
                 | (regs.diy & copy_cmd & (regs.sy == '0));
  assign chk_end = ~init & x_end & y_end;

  // Row write-backs happen in the loop check
  assign ny_upd = chk & ~init & x_end;
  assign y_upd  = ny_upd & copy_cmd;

  always_comb begin
    clr_wr = 1'b0;
    clr_in = clr & col_mask;
    // Re-mask color in case the mode changed
    if (chk && !chk_end) begin
      clr_wr = 1'b1;
    end
    if (run && state == ST_WAITSRC && !acc_busy && cur_cmd == CMD_POINT) begin
      clr_wr = 1'b1;
      clr_in = rd_point;
    end
  end

  // One access at a time, never while the port is busy
  always_comb begin
    acc_go = run & ~acc_busy
           & ((state == ST_RDSRC) | (state == ST_PRERD) | (state == ST_WR));
    acc_we = (state == ST_WR);
    acc_x  = x_cnt;
    acc_y  = regs.dy;
    x_low  = x_cnt[1:0];
    if (state == ST_RDSRC || state == ST_WAITSRC) begin
      acc_x = sx_cnt;
      acc_y = regs.sy;
      x_low = sx_cnt[1:0];
    end
  end

  assign acc_wdata = wdata;
  assign src_col   = copy_cmd ? src_pix : clr;

  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      state   <= ST_IDLE;
      init    <= 1'b0;
      ce      <= 1'b0;
      cur_cmd <= CMD_STOP;
      x_cnt   <= '0;
      sx_cnt  <= '0;
      nx_cnt  <= '0;
    end else begin
      // Status follows the state one edge later
      ce <= (state != ST_IDLE);
      if (start) begin
        cur_cmd <= regs.cmd;
        init    <= 1'b1;
        state   <= (regs.cmd == CMD_STOP) ? ST_IDLE : ST_CHKLOOP;
      end else if (!hold) begin
        case (state)
          ST_CHKLOOP: begin
            init <= 1'b0;
            if (chk_end) begin
              state <= ST_END;
            end else begin
              case (cur_cmd)
                CMD_HMMV:           state <= ST_WR;
                CMD_LMMV, CMD_PSET: state <= ST_PRERD;
                CMD_LMMM, CMD_POINT: state <= ST_RDSRC;
                default:            state <= ST_END;
              endcase
            end
            // First pass or new row
            if (init || x_end) begin
              x_cnt  <= {1'b0, regs.dx};
              sx_cnt <= {1'b0, regs.sx};
              nx_cnt <= nx_load;
            end
          end
          ST_RDSRC: begin
            if (!acc_busy) begin
              state <= ST_WAITSRC;
            end
          end
          ST_WAITSRC: begin
            if (!acc_busy) begin
              if (cur_cmd == CMD_POINT) begin
                state <= ST_END;
              end else begin
                sx_cnt <= sx_cnt + x_delta;
                state  <= ST_PRERD;
              end
            end
          end
          ST_PRERD: begin
            if (!acc_busy) begin
              state <= ST_WAITPRERD;
            end
          end
          ST_WAITPRERD: begin
            // Unchanged byte needs no write cycle
            if (!acc_busy) begin
              state <= (merged == rd_byte) ? ST_WAITWR : ST_WR;
            end
          end
          ST_WR: begin
            if (!acc_busy) begin
              state <= ST_WAITWR;
            end
          end
          ST_WAITWR: begin
            if (!acc_busy) begin
              if (cur_cmd == CMD_PSET) begin
                state <= ST_END;
              end else begin
                x_cnt  <= x_cnt + x_delta;
                nx_cnt <= nx_cnt - 1'b1;
                state  <= ST_CHKLOOP;
              end
            end
          end
          ST_END: begin
            cur_cmd <= CMD_STOP;
            state   <= ST_IDLE;
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  // Write byte and latched source pixel
  always_ff @(posedge reset) begin
    if (chk) begin
      wdata <= clr;
    end
    if (run && state == ST_WAITPRERD && !acc_busy) begin
      wdata <= merged;
    end
    if (run && state == ST_WAITSRC && !acc_busy) begin
      src_pix <= rd_point;
    end
  end

endmodule

`default_nettype wire

/* vdp_cmd_pixel.sv */
// Pixel datapath, purely combinational
// Color mask per mode, pixel extraction from the read byte
// Logical operation with transparency and merge into the byte
`timescale 1ns/1ps
`default_nettype none

module vdp_cmd_pixel (
  input  vdp_cmd_pkg::screen_mode_t mode,
  input  logic                      byte_cmd,
  input  logic                      tp,
  input  vdp_cmd_pkg::logop_t       op,
  input  vdp_cmd_pkg::color_t       src_col,
  input  vdp_cmd_pkg::color_t       rd_byte,
  input  logic [1:0]                x_low,
  output vdp_cmd_pkg::color_t       col_mask,
  output vdp_cmd_pkg::color_t       rd_point,
  output vdp_cmd_pkg::color_t       merged
);
  import vdp_cmd_pkg::*;

  logic   nib_mode;
  color_t src_m;
  color_t dest;

  // G4 and G6 pack two pixels per byte
  assign nib_mode = mode.g4 | mode.g6;
  assign src_m    = src_col & col_mask;

  always_comb begin
    if (byte_cmd) begin
      col_mask = 8'hff;
    end else if (nib_mode) begin
      col_mask = 8'h0f;
    end else if (mode.g5) begin
      col_mask = 8'h03;
    end else begin
      col_mask = 8'hff;
    end
  end

  // Addressed pixel, leftmost pixel in the high bits
  always_comb begin
    if (nib_mode) begin
      rd_point = x_low[0] ? {4'h0, rd_byte[3:0]} : {4'h0, rd_byte[7:4]};
    end else if (mode.g5) begin
      case (x_low)
        2'b00:   rd_point = {6'h00, rd_byte[7:6]};
        2'b01:   rd_point = {6'h00, rd_byte[5:4]};
        2'b10:   rd_point = {6'h00, rd_byte[3:2]};
        default: rd_point = {6'h00, rd_byte[1:0]};
      endcase
    end else begin
      rd_point = rd_byte;
    end
  end

  // Transparent and zero source keeps the destination
  always_comb begin
    if (tp && (src_m == 8'h00)) begin
      dest = rd_point;
    end else begin
      case (op)
        OP_IMP:  dest = src_m;
        OP_AND:  dest = src_m & rd_point;
        OP_OR:   dest = src_m | rd_point;
        OP_EOR:  dest = src_m ^ rd_point;
        OP_NOT:  dest = ~src_m;
        default: dest = rd_point;
      endcase
    end
  end

  // Splice the result back, other pixels untouched
  always_comb begin
    if (nib_mode) begin
      merged = x_low[0] ? {rd_byte[7:4], dest[3:0]} : {dest[3:0], rd_byte[3:0]};
    end else if (mode.g5) begin
      case (x_low)
        2'b00:   merged = {dest[1:0], rd_byte[5:0]};
        2'b01:   merged = {rd_byte[7:6], dest[1:0], rd_byte[3:0]};
        2'b10:   merged = {rd_byte[7:4], dest[1:0], rd_byte[1:0]};
        default: merged = {rd_byte[7:2], dest[1:0]};
      endcase
    end else begin
      merged = dest;
    end
  end

endmodule

`default_nettype wire

/* vdp_cmd_pkg.sv */
// Shared types for the block-graphics command engine
// Widths of addresses, coordinates, counters and colors
// Command and logical operation codes
// Screen mode bits, command register set and engine states
`default_nettype none

package vdp_cmd_pkg;

  // VRAM byte address, 128 KB
  localparam int VRAM_AW = 17;
  // R32 is the first command register
  localparam int REG_BASE = 32;

  typedef logic [VRAM_AW-1:0] vram_addr_t;
  typedef logic [7:0]         color_t;
  typedef logic [9:0]         coord_x_t;
  typedef logic [9:0]         coord_y_t;
  typedef logic [9:0]         count_t;
  typedef logic [3:0]         cmd_code_t;
  typedef logic [2:0]         logop_t;

  // Upper nibble of R46
  localparam cmd_code_t CMD_STOP  = 4'b0000;
  localparam cmd_code_t CMD_POINT = 4'b0100;
  localparam cmd_code_t CMD_PSET  = 4'b0101;
  localparam cmd_code_t CMD_LMMV  = 4'b1000;
  localparam cmd_code_t CMD_LMMM  = 4'b1001;
  localparam cmd_code_t CMD_HMMV  = 4'b1100;

  // Lower three bits of R46
  localparam logop_t OP_IMP = 3'b000;
  localparam logop_t OP_AND = 3'b001;
  localparam logop_t OP_OR  = 3'b010;
  localparam logop_t OP_EOR = 3'b011;
  localparam logop_t OP_NOT = 3'b100;

  // One-hot bitmap modes, G5 and G6 are high resolution
  typedef struct packed {
    logic g4;
    logic g5;
    logic g6;
    logic g7;
  } screen_mode_t;

  // Registers R32 to R46 as seen by the engine
  typedef struct packed {
    logic [8:0] sx;
    coord_y_t   sy;
    logic [8:0] dx;
    coord_y_t   dy;
    count_t     nx;
    count_t     ny;
    logic       dix;
    logic       diy;
    cmd_code_t  cmd;
    logic       tp;
    logop_t     op;
  } cmd_regs_t;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_CHKLOOP,
    ST_RDSRC,
    ST_WAITSRC,
    ST_PRERD,
    ST_WAITPRERD,
    ST_WR,
    ST_WAITWR,
    ST_END
  } eng_state_t;

endpackage

`default_nettype wire

/* vdp_cmd_regs.sv */
// Command register file R32 to R46
// Toggle write handshake with priority over the engine
// Loop write-backs of NY, SY and DY, color register updates
// Command start on an R46 write in a bitmap mode
`timescale 1ns/1ps
`default_nettype none

module vdp_cmd_regs (
  input  logic                      reset,
  input  logic                      clk21m,
  input  vdp_cmd_pkg::screen_mode_t mode,
  input  logic                      reg_wr_req,
  input  logic [3:0]                reg_num,
  input  vdp_cmd_pkg::color_t       reg_data,
  input  logic                      ce,
  input  vdp_cmd_pkg::color_t       col_mask,
  input  logic                      ny_upd,
  input  logic                      y_upd,
  input  logic                      clr_wr,
  input  vdp_cmd_pkg::color_t       clr_in,
  output logic                      reg_wr_ack,
  output vdp_cmd_pkg::cmd_regs_t    regs,
  output vdp_cmd_pkg::color_t       clr,
  output logic                      start,
  output logic                      hold
);
  import vdp_cmd_pkg::*;

  logic [5:0] reg_abs;
  coord_y_t   y_step;

  // Pending CPU write, engine stalls for this cycle
  assign hold    = (reg_wr_req != reg_wr_ack);
  assign reg_abs = 6'(REG_BASE) + {2'b00, reg_num};
  // DIY set means upward on screen
  assign y_step  = regs.diy ? '1 : 10'd1;

  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      reg_wr_ack <= 1'b0;
      regs       <= '0;
      clr        <= '0;
      start      <= 1'b0;
    end else begin
      start <= 1'b0;
      if (hold) begin
        reg_wr_ack <= ~reg_wr_ack;
        case (reg_abs)
          6'd32: regs.sx[7:0] <= reg_data;
          6'd33: regs.sx[8]   <= reg_data[0];
          6'd34: regs.sy[7:0] <= reg_data;
          6'd35: regs.sy[9:8] <= reg_data[1:0];
          6'd36: regs.dx[7:0] <= reg_data;
          6'd37: regs.dx[8]   <= reg_data[0];
          6'd38: regs.dy[7:0] <= reg_data;
          6'd39: regs.dy[9:8] <= reg_data[1:0];
          6'd40: regs.nx[7:0] <= reg_data;
          6'd41: regs.nx[9:8] <= reg_data[1:0];
          6'd42: regs.ny[7:0] <= reg_data;
          6'd43: regs.ny[9:8] <= reg_data[1:0];
          // Color written mid-command keeps only the pixel bits
          6'd44: clr <= ce ? (reg_data & col_mask) : reg_data;
          6'd45: begin
            regs.dix <= reg_data[2];
            regs.diy <= reg_data[3];
          end
          6'd46: begin
            regs.cmd <= reg_data[7:4];
            regs.tp  <= reg_data[3];
            regs.op  <= reg_data[2:0];
            // Any write restarts or aborts, bitmap modes only
            start    <= |mode;
          end
          default: ;
        endcase
      end else begin
        // Row done
        if (ny_upd) begin
          regs.ny <= regs.ny - 1'b1;
          regs.dy <= regs.dy + y_step;
        end
        // Source row of a copy
        if (y_upd) begin
          regs.sy <= regs.sy + y_step;
        end
        if (clr_wr) begin
          clr <= clr_in;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* vdp_command.sv */
// Block-graphics command engine, top level
// Register file, pixel datapath, engine FSM and VRAM port
`timescale 1ns/1ps
`default_nettype none

module vdp_command #(
  parameter int vram_aw = vdp_cmd_pkg::VRAM_AW
) (
  input  logic                      reset,
  input  logic                      clk21m,
  input  vdp_cmd_pkg::screen_mode_t mode,
  input  logic                      reg_wr_req,
  input  logic [3:0]                reg_num,
  input  vdp_cmd_pkg::color_t       reg_data,
  input  logic                      vram_wr_ack,
  input  logic                      vram_rd_ack,
  input  vdp_cmd_pkg::color_t       vram_rd_data,
  output logic                      reg_wr_ack,
  output logic                      vram_wr_req,
  output logic                      vram_rd_req,
  output logic [vram_aw-1:0]        vram_addr,
  output vdp_cmd_pkg::color_t       vram_wr_data,
  output vdp_cmd_pkg::color_t       clr,
  output logic                      ce,
  output vdp_cmd_pkg::cmd_code_t    cur_cmd
);
  import vdp_cmd_pkg::*;

  cmd_regs_t regs;
  logic      start;
  logic      hold;
  logic      ny_upd;
  logic      y_upd;
  logic      clr_wr;
  color_t    clr_in;
  color_t    col_mask;
  color_t    rd_point;
  color_t    merged;
  color_t    src_col;
  logic [1:0] x_low;
  logic      byte_cmd;
  // Engine to VRAM port
  logic      acc_go;
  logic      acc_we;
  logic      acc_busy;
  coord_x_t  acc_x;
  coord_y_t  acc_y;
  color_t    acc_wdata;

  vdp_cmd_regs i_vdp_cmd_regs (
    .reset      (reset),
    .clk21m     (clk21m),
    .mode       (mode),
    .reg_wr_req (reg_wr_req),
    .reg_num    (reg_num),
    .reg_data   (reg_data),
    .ce         (ce),
    .col_mask   (col_mask),
    .ny_upd     (ny_upd),
    .y_upd      (y_upd),
    .clr_wr     (clr_wr),
    .clr_in     (clr_in),
    .reg_wr_ack (reg_wr_ack),
    .regs       (regs),
    .clr        (clr),
    .start      (start),
    .hold       (hold)
  );

  vdp_cmd_pixel i_vdp_cmd_pixel (
    .mode     (mode),
    .byte_cmd (byte_cmd),
    .tp       (regs.tp),
    .op       (regs.op),
    .src_col  (src_col),
    .rd_byte  (vram_rd_data),
    .x_low    (x_low),
    .col_mask (col_mask),
    .rd_point (rd_point),
    .merged   (merged)
  );

  vdp_cmd_engine i_vdp_cmd_engine (
    .reset     (reset),
    .clk21m    (clk21m),
    .mode      (mode),
    .regs      (regs),
    .clr       (clr),
    .start     (start),
    .hold      (hold),
    .acc_busy  (acc_busy),
    .rd_point  (rd_point),
    .merged    (merged),
    .col_mask  (col_mask),
    .rd_byte   (vram_rd_data),
    .ce        (ce),
    .cur_cmd   (cur_cmd),
    .acc_go    (acc_go),
    .acc_we    (acc_we),
    .acc_x     (acc_x),
    .acc_y     (acc_y),
    .acc_wdata (acc_wdata),
    .x_low     (x_low),
    .src_col   (src_col),
    .byte_cmd  (byte_cmd),
    .ny_upd    (ny_upd),
    .y_upd     (y_upd),
    .clr_wr    (clr_wr),
    .clr_in    (clr_in)
  );

  vdp_vram_port #(
    .vram_aw (vram_aw)
  ) i_vdp_vram_port (
    .reset        (reset),
    .clk21m       (clk21m),
    .mode         (mode),
    .acc_go       (acc_go),
    .acc_we       (acc_we),
    .acc_x        (acc_x),
    .acc_y        (acc_y),
    .acc_wdata    (acc_wdata),
    .vram_wr_ack  (vram_wr_ack),
    .vram_rd_ack  (vram_rd_ack),
    .acc_busy     (acc_busy),
    .vram_wr_req  (vram_wr_req),
    .vram_rd_req  (vram_rd_req),
    .vram_addr    (vram_addr),
    .vram_wr_data (vram_wr_data)
  );

endmodule

`default_nettype wire

/* vdp_trace.txt */
// Entry kind_arg_val in hex. 1 write register arg (R32 = 20 is the base), 2 mode {g4,g5,g6,g7}
// 3 wait for ce low, 4 wait arg cycles, 5 VRAM[arg] == val, 6 clr == val, 7 cur_cmd == val, 0 end
// HMMV in G7, 3x2 bytes at (10,2)
2_00000_01
1_00024_0a
1_00025_00
1_00026_02
1_00027_00
1_00028_03
1_00029_00
1_0002a_02
1_0002b_00
1_0002c_a5
1_0002d_00
1_0002e_c0
3_00000_00
5_0020a_a5
5_0020c_a5
5_0030a_a5
5_0030c_a5
5_00209_0b
5_0020d_0f
5_0040a_0e
5_0010b_0a
6_00000_a5
// LMMV EOR in G4, three pixels from x=4 on row 5
2_00000_08
1_00024_04
1_00025_00
1_00026_05
1_00027_00
1_00028_03
1_00029_00
1_0002a_01
1_0002b_00
1_0002c_3c
1_0002d_00
1_0002e_83
3_00000_00
5_00282_4c
5_00283_41
5_00281_83
5_00284_86
6_00000_0c
// LMMV AND leftward from x=228 on row 6
1_00024_e4
1_00026_06
1_00028_03
1_0002a_01
1_0002c_05
1_0002d_04
1_0002e_81
3_00000_00
5_00372_51
5_00371_50
5_00370_73
// PSET in G5, transparent zero then OR 3 at (33,9)
2_00000_04
1_00024_21
1_00026_09
1_0002c_00
1_0002d_00
1_0002e_58
3_00000_00
5_00488_8c
1_0002c_03
1_0002e_52
3_00000_00
5_00488_bc
5_00489_8d
6_00000_03
// POINT in G6 at (259,5)
2_00000_02
1_00020_03
1_00021_01
1_00022_05
1_00023_00
1_0002e_40
3_00000_00
6_00000_04
7_00000_00
// LMMM NOT in G7 upward, source row 0 ends the copy
2_00000_01
1_00020_40
1_00021_00
1_00022_01
1_00024_80
1_00026_03
1_00028_02
1_0002a_05
1_0002d_08
1_0002e_94
3_00000_00
5_00380_be
5_00381_bf
5_00280_bf
5_00281_be
5_00180_81
5_00382_81
// Long HMMV aborted by STOP
1_00024_00
1_00026_40
1_00028_00
1_00029_01
1_0002a_40
1_0002c_33
1_0002d_00
1_0002e_c0
4_0003c_00
1_0002e_00
3_00000_00
7_00000_00
5_04000_33
1_0002c_5a
6_00000_5a
0_00000_00

/* vdp_vram_port.sv */
// VRAM access port of the command engine
// Mode-dependent address mapping, toggle read and write requests
// Registered address and write data, pending access tracking
`timescale 1ns/1ps
`default_nettype none

module vdp_vram_port #(
  parameter int vram_aw = vdp_cmd_pkg::VRAM_AW
) (
  input  logic                      reset,
  input  logic                      clk21m,
  input  vdp_cmd_pkg::screen_mode_t mode,
  input  logic                      acc_go,
  input  logic                      acc_we,
  input  vdp_cmd_pkg::coord_x_t     acc_x,
  input  vdp_cmd_pkg::coord_y_t     acc_y,
  input  vdp_cmd_pkg::color_t       acc_wdata,
  input  logic                      vram_wr_ack,
  input  logic                      vram_rd_ack,
  output logic                      acc_busy,
  output logic                      vram_wr_req,
  output logic                      vram_rd_req,
  output logic [vram_aw-1:0]        vram_addr,
  output vdp_cmd_pkg::color_t       vram_wr_data
);
  import vdp_cmd_pkg::*;

  vram_addr_t map_addr;

  // Row from Y, byte within the row from X
  always_comb begin
    if (mode.g4) begin
      map_addr = {acc_y, acc_x[7:1]};
    end else if (mode.g5) begin
      map_addr = {acc_y, acc_x[8:2]};
    end else if (mode.g6) begin
      map_addr = {acc_y[8:0], acc_x[8:1]};
    end else begin
      map_addr = {acc_y[8:0], acc_x[7:0]};
    end
  end

  // Request differs from ack while pending
  assign acc_busy = (vram_wr_req != vram_wr_ack) | (vram_rd_req != vram_rd_ack);

  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      vram_wr_req <= 1'b0;
      vram_rd_req <= 1'b0;
    end else if (acc_go) begin
      if (acc_we) begin
        vram_wr_req <= ~vram_wr_ack;
      end else begin
        vram_rd_req <= ~vram_rd_ack;
      end
    end
  end

  // Held for the whole access
  always_ff @(posedge reset) begin
    if (acc_go) begin
      vram_addr <= vram_aw'(map_addr);
      if (acc_we) begin
        vram_wr_data <= acc_wdata;
      end
    end
  end

endmodule

`default_nettype wire
